// File: hw/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// --------------------
// 800x600 at 40 MHz, horizontal in pixels
`define H_SYNC 128
`define H_BACK 88
`define H_ACTIVE 800
`define H_FRONT 40
`define H_TOTAL 1056

// vertical in lines
`define V_SYNC 4
`define V_BACK 23
`define V_ACTIVE 600
`define V_FRONT 1
`define V_TOTAL 628

// fetcher starts this many pixels before active video
`define FETCH_LEAD 8

// --------------------
// text row in memory and fixed colours (RGB565)
`define TEXT_BASE 16
`define TEXT_COLS 16
`define FG_COLOR 16'b10011_100111_10011
`define BG_COLOR 16'b00000_000111_01011

`endif

// File: hw/video_pkg.sv
`default_nettype none

package video_pkg;

	// one RGB565 pixel, r in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb_t;

	// font row, bit 7 is the leftmost pixel
	typedef logic [7:0] glyph_row_t;

	// raster counters
	typedef logic [10:0] hcount_t;
	typedef logic [9:0] vcount_t;

	// scanline inside an 8-line character
	typedef logic [2:0] char_scan_t;

endpackage

`default_nettype wire

// File: hw/video_timing_if.sv
`timescale 1ns/100ps
`default_nettype none

interface video_timing_if;

	logic hs;
	logic vs;
	logic de;
	logic line_start;
	logic fetch_en;
	video_pkg::char_scan_t char_scan;

	// raster generator drives everything
	modport source (
		output hs, vs, de, line_start, fetch_en, char_scan
	);

	// text fetcher only needs line and scanline info
	modport fetch (
		input line_start, fetch_en, char_scan
	);

	// pixel side re-registers sync with the pixels
	modport pixel (
		input hs, vs, de
	);

endinterface

`default_nettype wire

// File: hw/video_timing.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defs.svh"

module video_timing (
	input logic vga_clk,
	input logic reset_n,
	video_timing_if.source tim
);

	localparam int H_DE_START = `H_SYNC + `H_BACK;
	localparam int H_DE_END = H_DE_START + `H_ACTIVE;
	localparam int V_DE_START = `V_SYNC + `V_BACK;
	localparam int V_DE_END = V_DE_START + `V_ACTIVE;

	video_pkg::hcount_t h_cnt;
	video_pkg::vcount_t v_cnt;
	logic v_active;
	logic h_active;
	logic h_fetch;
	logic line_end;

	// --------------------
	// pixel and line counters
	always_ff @(posedge vga_clk) begin
		if (!reset_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == `V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign line_end = (h_cnt == `H_TOTAL - 1);
	assign v_active = (v_cnt >= V_DE_START) && (v_cnt < V_DE_END);
	assign h_active = (h_cnt >= H_DE_START) && (h_cnt < H_DE_END);
	// fetch window opens early so the FIFO holds a row at the first pixel
	assign h_fetch = (h_cnt >= H_DE_START - `FETCH_LEAD) && (h_cnt < H_DE_END);

	// --------------------
	// registered decode, all outputs lag the counters by one clock
	always_ff @(posedge vga_clk) begin
		if (!reset_n) begin
			tim.hs <= 1'b1;
			tim.vs <= 1'b1;
			tim.de <= 1'b0;
			tim.line_start <= 1'b0;
			tim.fetch_en <= 1'b0;
			tim.char_scan <= '0;
		end else begin
			tim.hs <= !(h_cnt < `H_SYNC);
			tim.vs <= !(v_cnt < `V_SYNC);
			tim.de <= h_active && v_active;
			tim.line_start <= (h_cnt == '0);
			tim.fetch_en <= h_fetch && v_active;
			// scanline restarts each frame, steps after every active line
			if (v_cnt == '0)
				tim.char_scan <= '0;
			else if (line_end && v_active)
				tim.char_scan <= tim.char_scan + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/text_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defs.svh"

module text_fetch (
	input logic vga_clk,
	input logic reset_n,
	video_timing_if.fetch tim,
	output logic [10:0] addr,
	input logic [7:0] data,
	input logic full,
	output logic push,
	output video_pkg::glyph_row_t push_row
);

	typedef enum logic [1:0] {
		S_TEXT,
		S_CODE,
		S_FONT,
		S_PUSH
	} state_t;

	state_t state;
	logic [3:0] col;
	logic [7:0] code_q;
	logic load_code;
	logic load_row;

	assign load_code = tim.fetch_en && (state == S_CODE);
	assign load_row = tim.fetch_en && (state == S_PUSH) && !full;

	// text address while reading the code, font address while reading the row
	// memory answers one clock later so each address is held two states
	always_comb begin
		if (state == S_TEXT || state == S_CODE)
			addr = 11'(`TEXT_BASE) + 11'(col);
		else
			addr = {code_q, tim.char_scan};
	end

	// --------------------
	// fetch FSM, one glyph row every 4 clocks
	always_ff @(posedge vga_clk) begin
		if (!reset_n) begin
			state <= S_TEXT;
			col <= '0;
			push <= 1'b0;
		end else if (tim.line_start) begin
			state <= S_TEXT;
			col <= '0;
			push <= 1'b0;
		end else begin
			push <= 1'b0;
			if (tim.fetch_en) begin
				case (state)
					S_TEXT: state <= S_CODE;
					S_CODE: state <= S_FONT;
					S_FONT: state <= S_PUSH;
					S_PUSH: begin
						// wait here while the FIFO is full
						if (!full) begin
							push <= 1'b1;
							col <= (col == `TEXT_COLS - 1) ? '0 : col + 1'b1;
							state <= S_TEXT;
						end
					end
					default: state <= S_TEXT;
				endcase
			end
		end
	end

	// captured bytes
	always_ff @(posedge vga_clk) begin
		if (load_code)
			code_q <= data;
		if (load_row)
			push_row <= data;
	end

endmodule

`default_nettype wire

// File: hw/glyph_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module glyph_fifo (
	input logic vga_clk,
	input logic reset_n,
	input logic flush,
	input logic push,
	input video_pkg::glyph_row_t push_row,
	input logic pop,
	output video_pkg::glyph_row_t pop_row,
	output logic full,
	output logic empty
);

	localparam int DEPTH = 4;

	video_pkg::glyph_row_t mem [DEPTH];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// pointers wrap naturally at 4
	always_ff @(posedge vga_clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge vga_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_row;
	end

	assign pop_row = mem[rd_ptr];
	assign full = (count == DEPTH);
	assign empty = (count == '0);

endmodule

`default_nettype wire

// File: hw/pixel_shifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defs.svh"

module pixel_shifter (
	input logic vga_clk,
	input logic reset_n,
	video_timing_if.pixel tim,
	input video_pkg::glyph_row_t pop_row,
	input logic empty,
	output logic pop,
	output logic vga_hs,
	output logic vga_vs,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b
);

	logic [2:0] pix_cnt;
	logic load;
	video_pkg::glyph_row_t shift_q;
	video_pkg::glyph_row_t cur_row;
	video_pkg::rgb_t rgb_q;

	// new row at every eighth pixel, taken straight from the FIFO head
	assign load = tim.de && (pix_cnt == 3'd0);
	assign pop = load && !empty;
	assign cur_row = (pix_cnt == 3'd0) ? pop_row : shift_q;

	// --------------------
	// output registers, one clock behind the raster
	always_ff @(posedge vga_clk) begin
		if (!reset_n) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			rgb_q <= '0;
			pix_cnt <= '0;
		end else begin
			vga_hs <= tim.hs;
			vga_vs <= tim.vs;
			if (tim.de) begin
				rgb_q <= cur_row[7] ? `FG_COLOR : `BG_COLOR;
				pix_cnt <= pix_cnt + 1'b1;
			end else begin
				rgb_q <= '0;
				pix_cnt <= '0;
			end
		end
	end

	// msb first
	always_ff @(posedge vga_clk) begin
		if (tim.de)
			shift_q <= {cur_row[6:0], 1'b0};
	end

	assign vga_r = rgb_q.r;
	assign vga_g = rgb_q.g;
	assign vga_b = rgb_q.b;

endmodule

`default_nettype wire

// File: hw/text_display.sv
`timescale 1ns/100ps
`default_nettype none

module text_display (
	input logic vga_clk,
	input logic reset_n,
	output logic vga_hs,
	output logic vga_vs,
	output logic [4:0] vga_r,
	output logic [5:0] vga_g,
	output logic [4:0] vga_b,
	output logic [10:0] addr_out,
	input logic [7:0] data_in
);

	logic fifo_full;
	logic fifo_empty;
	logic push;
	logic pop;
	video_pkg::glyph_row_t push_row;
	video_pkg::glyph_row_t pop_row;

	video_timing_if tim_if ();

	video_timing u_timing (
		.vga_clk (vga_clk),
		.reset_n (reset_n),
		.tim (tim_if.source)
	);

	// --------------------
	// producer, buffer, consumer
	text_fetch u_fetch (
		.vga_clk (vga_clk),
		.reset_n (reset_n),
		.tim (tim_if.fetch),
		.addr (addr_out),
		.data (data_in),
		.full (fifo_full),
		.push (push),
		.push_row (push_row)
	);

	// leftover rows are dropped at every line start
	glyph_fifo u_fifo (
		.vga_clk (vga_clk),
		.reset_n (reset_n),
		.flush (tim_if.line_start),
		.push (push),
		.push_row (push_row),
		.pop (pop),
		.pop_row (pop_row),
		.full (fifo_full),
		.empty (fifo_empty)
	);

	pixel_shifter u_shifter (
		.vga_clk (vga_clk),
		.reset_n (reset_n),
		.tim (tim_if.pixel),
		.pop_row (pop_row),
		.empty (fifo_empty),
		.pop (pop),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b)
	);

endmodule

`default_nettype wire

// File: tb/char_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defs.svh"

module char_mem_model (
	input logic vga_clk,
	input logic [10:0] addr,
	output logic [7:0] data
);

	logic [7:0] mem [2048];

	initial begin
		data = 8'h00;
		// font bytes everywhere, the text row is laid over them below
		for (int a = 0; a < 2048; a++)
			mem[a] = 8'(a) ^ 8'hA5;
		void'($urandom(2));
		// codes kept at 32 and up so font reads never land in the text row
		for (int i = 0; i < `TEXT_COLS; i++)
			mem[`TEXT_BASE + i] = 8'(32 + ($urandom % 224));
	end

	// one clock read latency, no enable
	always @(posedge vga_clk) begin
		data <= mem[addr];
	end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defs.svh"

module tb_top;

	localparam int CLK_HALF = 20;
	localparam int H_DE_START = `H_SYNC + `H_BACK;
	localparam int V_DE_START = `V_SYNC + `V_BACK;
	localparam int WATCHDOG_NS = 3 * `H_TOTAL * `V_TOTAL * 2 * CLK_HALF + 100000;

	logic vga_clk;
	logic reset_n;
	logic vga_hs;
	logic vga_vs;
	logic [4:0] vga_r;
	logic [5:0] vga_g;
	logic [4:0] vga_b;
	logic [10:0] addr_out;
	logic [7:0] data_in;
	logic [15:0] rgb;

	logic [7:0] text_codes [`TEXT_COLS];
	logic [7:0] last_code;
	logic [15:0] expected;
	logic aligned = 1'b0;
	logic prev_hs = 1'b1;
	logic prev_text = 1'b0;
	logic addr_text;
	logic active_line;
	logic post_reset_done = 1'b0;
	int h = 0;
	int v = 0;
	int frames_done = 0;
	int pixel_checks = 0;
	int reset_errors = 0;
	int sync_errors = 0;
	int blank_errors = 0;
	int pixel_errors = 0;
	int addr_errors = 0;

	text_display dut0 (
		.vga_clk (vga_clk),
		.reset_n (reset_n),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.addr_out (addr_out),
		.data_in (data_in)
	);

	char_mem_model mem0 (
		.vga_clk (vga_clk),
		.addr (addr_out),
		.data (data_in)
	);

	assign rgb = {vga_r, vga_g, vga_b};

	initial begin
		vga_clk = 1'b0;
		forever #(CLK_HALF) vga_clk = ~vga_clk;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: two frames did not complete within %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

	// pixel k of line y from the text row and the font rule
	function automatic logic [15:0] expected_pixel(int k, int y);
		logic [7:0] code;
		int font_addr;
		video_pkg::glyph_row_t font_byte;
		code = text_codes[(k / 8) % `TEXT_COLS];
		font_addr = code * 8 + ((y - V_DE_START) % 8);
		font_byte = 8'(font_addr) ^ 8'hA5;
		if (font_byte[7 - (k % 8)])
			return `FG_COLOR;
		else
			return `BG_COLOR;
	endfunction

	// --------------------
	// reset and then two aligned frames
	initial begin : main_flow
		int total_errors;
		reset_n <= 1'b0;
		repeat (10) @(negedge vga_clk);
		reset_n <= 1'b1;
		for (int i = 0; i < `TEXT_COLS; i++)
			text_codes[i] = mem0.mem[`TEXT_BASE + i];
		wait (frames_done >= 2);
		@(negedge vga_clk);
		total_errors = reset_errors + sync_errors + blank_errors + pixel_errors + addr_errors;
		$display("pixels checked %0d, errors: reset %0d sync %0d blank %0d pixel %0d addr %0d",
			pixel_checks, reset_errors, sync_errors, blank_errors, pixel_errors, addr_errors);
		if (total_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// --------------------
	// all checks sample on the falling edge
	always @(negedge vga_clk) begin
		// code returned for the text address of the previous cycle
		if (prev_text)
			last_code = data_in;
		addr_text = (addr_out >= `TEXT_BASE) && (addr_out < `TEXT_BASE + `TEXT_COLS);
		prev_text = addr_text;

		if (!reset_n || !post_reset_done) begin
			assert (vga_hs && vga_vs && rgb == '0) else begin
				reset_errors++;
				$display("** Error at %0d ns: outputs not idle around reset, hs %b vs %b rgb %h",
					$time, vga_hs, vga_vs, rgb);
			end
			if (reset_n)
				post_reset_done = 1'b1;
		end

		// reference raster starts at the first hs fall
		if (!aligned && prev_hs && !vga_hs) begin
			aligned = 1'b1;
			h = 0;
			v = 0;
		end
		prev_hs = vga_hs;

		if (aligned) begin
			assert (vga_hs == (h >= `H_SYNC) && vga_vs == (v >= `V_SYNC)) else begin
				sync_errors++;
				$display("** Error at %0d ns: sync wrong at line %0d pixel %0d, hs %b vs %b",
					$time, v, h, vga_hs, vga_vs);
			end
			active_line = (v >= V_DE_START) && (v < V_DE_START + `V_ACTIVE);
			if (active_line && h >= H_DE_START && h < H_DE_START + `H_ACTIVE) begin
				pixel_checks++;
				expected = expected_pixel(h - H_DE_START, v);
				assert (rgb == expected) else begin
					pixel_errors++;
					$display("** Error at %0d ns: line %0d pixel %0d is %h, expected %h",
						$time, v, h - H_DE_START, rgb, expected);
				end
			end else begin
				assert (rgb == '0) else begin
					blank_errors++;
					$display("** Error at %0d ns: rgb %h in blanking at line %0d count %0d",
						$time, rgb, v, h);
				end
			end
			// fetch must alternate text reads with fonts of the code just read
			if (active_line) begin
				assert (addr_text || addr_out[10:3] == last_code) else begin
					addr_errors++;
					$display("** Error at %0d ns: addr %h is neither text nor font of code %h",
						$time, addr_out, last_code);
				end
			end
			if (h == `H_TOTAL - 1) begin
				h = 0;
				if (v == `V_TOTAL - 1) begin
					v = 0;
					frames_done++;
				end else begin
					v++;
				end
			end else begin
				h++;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/video_pkg.sv
hw/video_timing_if.sv
hw/video_timing.sv
hw/text_fetch.sv
hw/glyph_fifo.sv
hw/pixel_shifter.sv
hw/text_display.sv
tb/char_mem_model.sv
tb/tb_top.sv

// File: Makefile
TOP = tb_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
